//--- files.f
verilog/spritePkg.sv
verilog/displayPkg.sv
verilog/spriteRom.sv
verilog/objectTable.sv
verilog/spriteSlot.sv
verilog/pixelMixer.sv
verilog/spriteEngine.sv
verification/clockGen.sv
verification/spriteEngineTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the sprite engine testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module spriteEngineTb -f files.f -o simSpriteEngine
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simSpriteEngine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int HalfPeriod  = 4,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic arstN
);
    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 arstN = 1'b1;  // Released off the edge
    end

endmodule

//--- verification/spriteEngineTb.sv
`timescale 1ns/1ns

module spriteEngineTb;
    import spritePkg::*;
    import displayPkg::*;

    localparam int NumSlots    = 4;
    localparam int ScreenWidth = 64;
    localparam int SlotBits    = 2;
    localparam int ClockPeriod = 8;
    localparam int NumLines    = 1 + 80 + 32 + 40 + 2;
    localparam int WatchdogNs  = (NumLines * (ScreenWidth + 10) + 500) * ClockPeriod;
    localparam int LineTimeout = 20;  // Cycles to wait for the first pixel

    logic                clk;
    logic                arstN;
    logic                writeEn;
    logic [SlotBits-1:0] writeSlot;
    coordT               writeX;
    coordT               writeY;
    spriteIdT            writeSprite;
    orientT              writeOrient;
    logic                writeActive;
    logic                lineStart;
    coordT               lineRow;
    logic                lineBusy;
    logic                pixelValid;
    coordT               pixelX;
    logic                pixelOn;
    logic [SlotBits-1:0] pixelSlot;

    // Model copy of the table
    logic     mActive [NumSlots];
    coordT    mX      [NumSlots];
    coordT    mY      [NumSlots];
    spriteIdT mSprite [NumSlots];
    orientT   mOrient [NumSlots];

    int errorCount  = 0;
    int checkCount  = 0;
    int testsRun    = 0;
    int testsFailed = 0;
    int testErrBase = 0;

    // Row 0 first, column c at bit 7-c, a 0 is a lit pixel
    logic [7:0] bitmapRows [9][8] = '{
        '{8'b11000111, 8'b10000011, 8'b10000001, 8'b11000000,
          8'b11001000, 8'b10010001, 8'b10000011, 8'b11000111},
        '{8'b11101111, 8'b11101111, 8'b11101111, 8'b11101111,
          8'b11101111, 8'b11101111, 8'b11000111, 8'b11101111},
        '{8'b11111111, 8'b11000011, 8'b10110000, 8'b00000011,
          8'b00110001, 8'b00000000, 8'b01000001, 8'b11111111},
        '{8'b11111011, 8'b11100011, 8'b11001000, 8'b11000011,
          8'b10001001, 8'b10000000, 8'b10010001, 8'b11111111},
        '{8'b11000011, 8'b11100001, 8'b10000011, 8'b10000001,
          8'b00000001, 8'b01000000, 8'b11100001, 8'b11000001},
        '{8'b11000011, 8'b11100001, 8'b11000011, 8'b10000001,
          8'b10000000, 8'b10000000, 8'b10000001, 8'b11000001},
        '{8'b11000111, 8'b11000011, 8'b11000011, 8'b10010001,
          8'b10110001, 8'b10100001, 8'b01000011, 8'b11000111},
        '{8'b11001111, 8'b10000011, 8'b10011000, 8'b01111011,
          8'b01111011, 8'b01111000, 8'b10111011, 8'b11000111},
        '{8'b11100111, 8'b11000001, 8'b11001100, 8'b10111101,
          8'b10111101, 8'b10111100, 8'b11011101, 8'b11100011}
    };

    clockGen #(.HalfPeriod(ClockPeriod / 2), .ResetCycles(5)) i_clockGen (
        .clk   (clk),
        .arstN (arstN)
    );

    spriteEngine #(
        .NumSlots    (NumSlots),
        .ScreenWidth (ScreenWidth)
    ) i_spriteEngine (
        .clk         (clk),
        .arstN       (arstN),
        .writeEn     (writeEn),
        .writeSlot   (writeSlot),
        .writeX      (writeX),
        .writeY      (writeY),
        .writeSprite (writeSprite),
        .writeOrient (writeOrient),
        .writeActive (writeActive),
        .lineStart   (lineStart),
        .lineRow     (lineRow),
        .lineBusy    (lineBusy),
        .pixelValid  (pixelValid),
        .pixelX      (pixelX),
        .pixelOn     (pixelOn),
        .pixelSlot   (pixelSlot)
    );

    task automatic tick();
        @(posedge clk);
        #1;  // Sample and drive just after the edge
    endtask

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR %s", msg);
    endtask

    task automatic checkOn(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s pixelOn expected %0b actual %0b", name, expected, actual);
        end
    endtask

    task automatic checkSlot(input string name, input logic [SlotBits-1:0] expected,
                             input logic [SlotBits-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s pixelSlot expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkX(input string name, input coordT expected, input coordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s pixelX expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic logic storedOn(input spriteIdT id, input int r, input int c);
        if (int'(id) > 8) begin
            return 1'b0;  // Blank sprite numbers
        end
        return !bitmapRows[int'(id)][r][7 - c];
    endfunction

    task automatic modelPixel(input coordT row, input coordT col, output logic on,
                              output logic [SlotBits-1:0] slot);
        coordT dr;
        coordT dc;
        int    l;
        int    k;
        logic  px;
        on   = 1'b0;
        slot = '0;
        // Walk down so the lowest slot has the last word
        for (int s = NumSlots - 1; s >= 0; s--) begin
            dr = row - mY[s];
            dc = col - mX[s];
            if (mActive[s] && dr < 8'd8 && dc < 8'd8) begin
                l = int'(dr);
                k = int'(dc);
                case (mOrient[s])
                    Up:      px = storedOn(mSprite[s], l, k);
                    Down:    px = storedOn(mSprite[s], 7 - l, 7 - k);
                    Right:   px = storedOn(mSprite[s], 7 - k, l);
                    default: px = storedOn(mSprite[s], k, l);
                endcase
                if (px) begin
                    on   = 1'b1;
                    slot = SlotBits'(s);
                end
            end
        end
    endtask

    task automatic writeEntry(input int slot, input coordT x, input coordT y,
                              input spriteIdT id, input orientT o, input logic act);
        writeEn     = 1'b1;
        writeSlot   = SlotBits'(slot);
        writeX      = x;
        writeY      = y;
        writeSprite = id;
        writeOrient = o;
        writeActive = act;
        tick();
        writeEn = 1'b0;
        mX[slot]      = x;
        mY[slot]      = y;
        mSprite[slot] = id;
        mOrient[slot] = o;
        mActive[slot] = act;
    endtask

    // Requests one row and checks every pixel, optionally poking the busy inputs
    task automatic runLine(input string testName, input coordT row, input bit disturb);
        int                  cycles;
        int                  count;
        logic                expOn;
        logic [SlotBits-1:0] expSlot;
        string               tag;
        lineRow   = row;
        lineStart = 1'b1;
        tick();
        lineStart = 1'b0;
        cycles    = 1;
        count     = 0;
        while (!pixelValid && cycles < LineTimeout) begin
            tick();
            cycles++;
        end
        if (!pixelValid) begin
            reportError($sformatf("%s row %0d: no pixel came out of the engine", testName, row));
            return;
        end
        if (cycles != 4) begin
            reportError($sformatf("%s row %0d: first pixel came %0d cycles after lineStart, not 4",
                                  testName, row, cycles));
        end
        while (pixelValid) begin
            if (count < ScreenWidth) begin
                tag = $sformatf("%s row %0d col %0d", testName, row, count);
                modelPixel(row, coordT'(count), expOn, expSlot);
                checkX(tag, coordT'(count), pixelX);
                checkOn(tag, expOn, pixelOn);
                checkSlot(tag, expSlot, pixelSlot);
            end
            count++;
            if (disturb && count == 10) begin
                writeEn     = 1'b1;  // Must be dropped while busy
                writeSlot   = '0;
                writeX      = mX[0] + 8'd3;
                writeSprite = Sword;
                writeOrient = Right;
                writeActive = 1'b1;
                lineStart   = 1'b1;  // Must be ignored while busy
                lineRow     = row + 8'd1;
            end else if (disturb && count == 11) begin
                writeEn   = 1'b0;
                lineStart = 1'b0;
            end
            tick();
        end
        if (count != ScreenWidth) begin
            reportError($sformatf("%s row %0d: got %0d pixels instead of %0d",
                                  testName, row, count, ScreenWidth));
        end
        if (lineBusy) begin
            reportError($sformatf("%s row %0d: lineBusy still high after the line", testName, row));
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == testErrBase) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errorCount - testErrBase);
        end
        testErrBase = errorCount;
    endtask

    // Mostly on screen, sometimes just below 256 to wrap
    function automatic coordT randomCoord();
        if ($urandom % 2) begin
            return coordT'(248 + $urandom % 8);
        end
        return coordT'($urandom % 64);
    endfunction

    initial begin : watchdog
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the run did not finish", WatchdogNs);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : mainSeq
        spriteIdT sid;
        coordT    row;
        bit       extraLine;
        writeEn     = 1'b0;
        writeSlot   = '0;
        writeX      = '0;
        writeY      = '0;
        writeSprite = Heart;
        writeOrient = Up;
        writeActive = 1'b0;
        lineStart   = 1'b0;
        lineRow     = '0;
        for (int s = 0; s < NumSlots; s++) begin
            mActive[s] = 1'b0;
            mX[s]      = '0;
            mY[s]      = '0;
            mSprite[s] = Heart;
            mOrient[s] = Up;
        end
        void'($urandom(90));
        wait (arstN === 1'b1);
        tick();

        runLine("idle", 8'd0, 1'b0);
        finishTest("1 idle line");

        for (int id = 0; id < 10; id++) begin
            sid = (id == 9) ? spriteIdT'(4'd12) : spriteIdT'(id);  // Last one is blank
            writeEntry(2, coordT'($urandom % 57), 8'd20, sid, Up, 1'b1);
            for (int r = 0; r < 8; r++) begin
                runLine($sformatf("single sprite %0d", id), coordT'(20 + r), 1'b0);
            end
        end
        finishTest("2 single sprite");

        writeEntry(2, 8'd0, 8'd0, Heart, Up, 1'b0);
        for (int o = 0; o < 4; o++) begin
            writeEntry(0, coordT'($urandom % 57), coordT'($urandom % 256),
                       spriteIdT'($urandom % 9), orientT'(o), 1'b1);
            for (int r = 0; r < 8; r++) begin
                runLine($sformatf("orient %0d", o), mY[0] + coordT'(r), 1'b0);
            end
        end
        finishTest("3 orientations");

        for (int cfg = 0; cfg < 4; cfg++) begin
            for (int s = 0; s < NumSlots; s++) begin
                writeEntry(s, randomCoord(), randomCoord(), spriteIdT'($urandom % 9),
                           orientT'($urandom % 4), ($urandom % 8) != 0);
            end
            for (int r = 0; r < 10; r++) begin
                if (r % 4 == 3) begin
                    row = coordT'($urandom % 256);
                end else begin
                    row = mY[$urandom % NumSlots] + coordT'($urandom % 8);
                end
                runLine($sformatf("overlap cfg %0d", cfg), row, 1'b0);
            end
        end
        finishTest("4 overlap priority");

        writeEntry(0, 8'd10, 8'd30, DragonHead, Up, 1'b1);
        runLine("busy line", 8'd33, 1'b1);
        extraLine = 1'b0;
        repeat (12) begin
            tick();
            if (pixelValid) begin
                extraLine = 1'b1;
            end
        end
        if (extraLine) begin
            reportError("busy rules: a lineStart during a line started another line");
        end
        runLine("after busy", 8'd33, 1'b0);
        finishTest("5 busy rules");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/displayPkg.sv
package displayPkg;

    parameter int CoordWidth = 8;  // Row and column width

    typedef logic [CoordWidth-1:0] coordT;  // Screen row or column

    parameter int SpriteSize = 8;  // Sprite edge in pixels

endpackage

//--- verilog/objectTable.sv
`timescale 1ns/1ns

module objectTable #(
    parameter  int NumSlots    = 4,
    parameter  int ScreenWidth = 64,
    localparam int SlotBits    = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                writeEn,
    input  logic [SlotBits-1:0]                 writeSlot,
    input  displayPkg::coordT                   writeX,
    input  displayPkg::coordT                   writeY,
    input  spritePkg::spriteIdT                 writeSprite,
    input  spritePkg::orientT                   writeOrient,
    input  logic                                writeActive,
    input  logic                                lineStart,
    input  displayPkg::coordT                   lineRow,
    output logic                                lineBusy,
    output logic                                fetch,
    output logic                                scanValid,
    output displayPkg::coordT                   scanCol,
    output logic [NumSlots-1:0]                 hit,
    output logic [NumSlots-1:0][2:0]            lineIndex,
    output spritePkg::spriteIdT [NumSlots-1:0]  spriteId,
    output spritePkg::orientT [NumSlots-1:0]    orient,
    output displayPkg::coordT [NumSlots-1:0]    xPos
);
    import displayPkg::*;

    localparam coordT LastCol = CoordWidth'(ScreenWidth - 1);

    logic                 writeAccept;
    logic                 lineAccept;
    logic [NumSlots-1:0]  active;
    coordT [NumSlots-1:0] yPos;
    coordT [NumSlots-1:0] rowOffset;  // Requested row minus yPos, wraps at 256

    assign writeAccept = writeEn && !lineBusy;  // Table frozen during a line
    assign lineAccept  = lineStart && !lineBusy;

    always_comb begin
        for (int s = 0; s < NumSlots; s++) begin
            rowOffset[s] = lineRow - yPos[s];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            active <= '0;
        end else if (writeAccept) begin
            for (int s = 0; s < NumSlots; s++) begin
                if (writeSlot == SlotBits'(s)) begin
                    active[s] <= writeActive;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeAccept) begin
            for (int s = 0; s < NumSlots; s++) begin
                if (writeSlot == SlotBits'(s)) begin
                    xPos[s]     <= writeX;
                    yPos[s]     <= writeY;
                    spriteId[s] <= writeSprite;
                    orient[s]   <= writeOrient;
                end
            end
        end
    end

    // Row hit is judged once per line
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hit <= '0;
        end else if (lineAccept) begin
            for (int s = 0; s < NumSlots; s++) begin
                hit[s] <= active[s] && (rowOffset[s] < CoordWidth'(SpriteSize));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lineAccept) begin
            for (int s = 0; s < NumSlots; s++) begin
                lineIndex[s] <= rowOffset[s][2:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lineBusy  <= 1'b0;
            fetch     <= 1'b0;
            scanValid <= 1'b0;
            scanCol   <= '0;
        end else begin
            fetch <= lineAccept;  // One cycle ROM read
            if (lineAccept) begin
                lineBusy <= 1'b1;
            end
            if (fetch) begin
                scanValid <= 1'b1;  // Column 0 follows the fetch
                scanCol   <= '0;
            end else if (scanValid) begin
                if (scanCol == LastCol) begin
                    scanValid <= 1'b0;
                    lineBusy  <= 1'b0;
                end else begin
                    scanCol <= scanCol + 1'b1;
                end
            end
        end
    end

    // A fetch only opens a new line, never one that is already scanning
    fetchFollowsStart: assert property (@(posedge clk) disable iff (!arstN)
        fetch |-> lineBusy && !scanValid);

endmodule

//--- verilog/pixelMixer.sv
`timescale 1ns/1ns

module pixelMixer #(
    parameter  int NumSlots = 4,
    localparam int SlotBits = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                scanValid,
    input  displayPkg::coordT   scanCol,
    input  logic [NumSlots-1:0] drawOn,
    output logic                pixelValid,
    output displayPkg::coordT   pixelX,
    output logic                pixelOn,
    output logic [SlotBits-1:0] pixelSlot
);
    import displayPkg::*;

    logic                validDly;  // Aligned with drawOn
    coordT               colDly;
    logic [SlotBits-1:0] winner;

    // Lowest slot number wins
    always_comb begin
        winner = '0;
        for (int s = NumSlots - 1; s >= 0; s--) begin
            if (drawOn[s]) begin
                winner = SlotBits'(s);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validDly   <= 1'b0;
            pixelValid <= 1'b0;
        end else begin
            validDly   <= scanValid;
            pixelValid <= validDly;
        end
    end

    always_ff @(posedge clk) begin
        colDly    <= scanCol;
        pixelX    <= colDly;
        pixelOn   <= |drawOn;
        pixelSlot <= winner;  // Zero when nothing draws
    end

    columnsAscend: assert property (@(posedge clk) disable iff (!arstN)
        pixelValid && $past(pixelValid) |-> pixelX == coordT'($past(pixelX) + 1'b1));

endmodule

//--- verilog/spriteEngine.sv
`timescale 1ns/1ns

module spriteEngine #(
    parameter  int NumSlots    = 4,
    parameter  int ScreenWidth = 64,
    localparam int SlotBits    = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                writeEn,
    input  logic [SlotBits-1:0] writeSlot,
    input  displayPkg::coordT   writeX,
    input  displayPkg::coordT   writeY,
    input  spritePkg::spriteIdT writeSprite,
    input  spritePkg::orientT   writeOrient,
    input  logic                writeActive,
    input  logic                lineStart,
    input  displayPkg::coordT   lineRow,
    output logic                lineBusy,
    output logic                pixelValid,
    output displayPkg::coordT   pixelX,
    output logic                pixelOn,
    output logic [SlotBits-1:0] pixelSlot
);
    import spritePkg::*;
    import displayPkg::*;

    logic                       fetch;
    logic                       scanValid;
    coordT                      scanCol;
    logic [NumSlots-1:0]        hit;
    logic [NumSlots-1:0][2:0]   lineIndex;
    spriteIdT [NumSlots-1:0]    spriteId;
    orientT [NumSlots-1:0]      orient;
    coordT [NumSlots-1:0]       xPos;
    logic [NumSlots-1:0]        drawOn;

    objectTable #(
        .NumSlots    (NumSlots),
        .ScreenWidth (ScreenWidth)
    ) i_objectTable (
        .clk         (clk),
        .arstN       (arstN),
        .writeEn     (writeEn),
        .writeSlot   (writeSlot),
        .writeX      (writeX),
        .writeY      (writeY),
        .writeSprite (writeSprite),
        .writeOrient (writeOrient),
        .writeActive (writeActive),
        .lineStart   (lineStart),
        .lineRow     (lineRow),
        .lineBusy    (lineBusy),
        .fetch       (fetch),
        .scanValid   (scanValid),
        .scanCol     (scanCol),
        .hit         (hit),
        .lineIndex   (lineIndex),
        .spriteId    (spriteId),
        .orient      (orient),
        .xPos        (xPos)
    );

    for (genvar s = 0; s < NumSlots; s++) begin : gSlot
        spriteSlot i_spriteSlot (
            .clk       (clk),
            .arstN     (arstN),
            .fetch     (fetch),
            .hit       (hit[s]),
            .lineIndex (lineIndex[s]),
            .spriteId  (spriteId[s]),
            .orient    (orient[s]),
            .xPos      (xPos[s]),
            .scanValid (scanValid),
            .scanCol   (scanCol),
            .drawOn    (drawOn[s])
        );
    end

    pixelMixer #(
        .NumSlots (NumSlots)
    ) i_pixelMixer (
        .clk        (clk),
        .arstN      (arstN),
        .scanValid  (scanValid),
        .scanCol    (scanCol),
        .drawOn     (drawOn),
        .pixelValid (pixelValid),
        .pixelX     (pixelX),
        .pixelOn    (pixelOn),
        .pixelSlot  (pixelSlot)
    );

endmodule

//--- verilog/spritePkg.sv
package spritePkg;

    // Sprite numbers held by the bitmap store
    typedef enum logic [3:0] {
        Heart          = 4'd0,
        Sword          = 4'd1,
        GnomeIdle1     = 4'd2,
        GnomeIdle2     = 4'd3,
        DragonWingUp   = 4'd4,
        DragonWingDown = 4'd5,
        DragonHead     = 4'd6,
        SheepIdle1     = 4'd7,
        SheepIdle2     = 4'd8
    } spriteIdT;  // 9 to 15 read as a blank line

    typedef enum logic [1:0] {
        Up    = 2'd0,  // As stored
        Right = 2'd1,  // Quarter turn clockwise
        Down  = 2'd2,  // Half turn
        Left  = 2'd3   // Mirrored on the main diagonal
    } orientT;

    typedef logic [7:0] lineBitsT;  // Bit i is column i, 1 is on

endpackage

//--- verilog/spriteRom.sv
`timescale 1ns/1ns

module spriteRom (
    input  logic                clk,
    input  logic                readEnable,
    input  spritePkg::spriteIdT spriteId,
    input  spritePkg::orientT   orient,
    input  logic [2:0]          lineIndex,
    output spritePkg::lineBitsT lineBits
);
    import spritePkg::*;

    logic [63:0] bitmapBits;  // Active-low bitmap of the selected sprite
    lineBitsT    nextLine;

    // Stored row 0 sits in the top byte, and column c of a row is bit 7-c of its byte.
    // So pixel (r,c) lives at bit {~r,~c}
    function automatic logic [63:0] bitmapOf(spriteIdT id);
        logic [63:0] bmp;
        case (id)
            Heart:          bmp = {8'b11000111, 8'b10000011, 8'b10000001, 8'b11000000,
                                   8'b11001000, 8'b10010001, 8'b10000011, 8'b11000111};
            Sword:          bmp = {8'b11101111, 8'b11101111, 8'b11101111, 8'b11101111,
                                   8'b11101111, 8'b11101111, 8'b11000111, 8'b11101111};
            GnomeIdle1:     bmp = {8'b11111111, 8'b11000011, 8'b10110000, 8'b00000011,
                                   8'b00110001, 8'b00000000, 8'b01000001, 8'b11111111};
            GnomeIdle2:     bmp = {8'b11111011, 8'b11100011, 8'b11001000, 8'b11000011,
                                   8'b10001001, 8'b10000000, 8'b10010001, 8'b11111111};
            DragonWingUp:   bmp = {8'b11000011, 8'b11100001, 8'b10000011, 8'b10000001,
                                   8'b00000001, 8'b01000000, 8'b11100001, 8'b11000001};
            DragonWingDown: bmp = {8'b11000011, 8'b11100001, 8'b11000011, 8'b10000001,
                                   8'b10000000, 8'b10000000, 8'b10000001, 8'b11000001};
            DragonHead:     bmp = {8'b11000111, 8'b11000011, 8'b11000011, 8'b10010001,
                                   8'b10110001, 8'b10100001, 8'b01000011, 8'b11000111};
            SheepIdle1:     bmp = {8'b11001111, 8'b10000011, 8'b10011000, 8'b01111011,
                                   8'b01111011, 8'b01111000, 8'b10111011, 8'b11000111};
            SheepIdle2:     bmp = {8'b11100111, 8'b11000001, 8'b11001100, 8'b10111101,
                                   8'b10111101, 8'b10111100, 8'b11011101, 8'b11100011};
            default:        bmp = '1;  // Blank tile
        endcase
        return bmp;
    endfunction

    assign bitmapBits = bitmapOf(spriteId);

    // Map each output pixel back to a stored pixel
    always_comb begin : orientSelect
        logic [2:0] srcRow;
        logic [2:0] srcCol;
        nextLine = '0;
        for (int i = 0; i < 8; i++) begin
            case (orient)
                Up: begin
                    srcRow = lineIndex;
                    srcCol = 3'(i);
                end
                Down: begin
                    srcRow = ~lineIndex;
                    srcCol = ~3'(i);
                end
                Right: begin
                    srcRow = ~3'(i);
                    srcCol = lineIndex;
                end
                default: begin  // Left
                    srcRow = 3'(i);
                    srcCol = lineIndex;
                end
            endcase
            nextLine[i] = ~bitmapBits[{~srcRow, ~srcCol}];  // Stored data is active low
        end
    end

    always_ff @(posedge clk) begin
        if (readEnable) begin
            lineBits <= nextLine;
        end
    end

endmodule

//--- verilog/spriteSlot.sv
`timescale 1ns/1ns

module spriteSlot (
    input  logic                clk,
    input  logic                arstN,
    input  logic                fetch,
    input  logic                hit,
    input  logic [2:0]          lineIndex,
    input  spritePkg::spriteIdT spriteId,
    input  spritePkg::orientT   orient,
    input  displayPkg::coordT   xPos,
    input  logic                scanValid,
    input  displayPkg::coordT   scanCol,
    output logic                drawOn
);
    import spritePkg::*;
    import displayPkg::*;

    lineBitsT lineBits;    // Valid from the cycle after fetch
    coordT    colOffset;   // Column within the sprite, wraps at 256
    logic     inSprite;
    logic     hitAtFetch;

    spriteRom i_spriteRom (
        .clk        (clk),
        .readEnable (fetch),
        .spriteId   (spriteId),
        .orient     (orient),
        .lineIndex  (lineIndex),
        .lineBits   (lineBits)
    );

    assign colOffset = scanCol - xPos;
    assign inSprite  = colOffset < CoordWidth'(SpriteSize);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            drawOn     <= 1'b0;
            hitAtFetch <= 1'b0;
        end else begin
            if (fetch) begin
                hitAtFetch <= hit;
            end
            drawOn <= scanValid && hit && inSprite && lineBits[colOffset[2:0]];
        end
    end

    // Row hit must hold from the fetch through the whole scan
    drawNeedsHit: assert property (@(posedge clk) disable iff (!arstN)
        drawOn |-> hitAtFetch);

endmodule
